//--- verilog/mips_isa_pkg.sv
package mips_isa_pkg;

    // Register file geometry.
    localparam int NUM_REGS = 32;

    typedef logic [31:0] instr_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [10:0] pc_addr_t;
    typedef logic [15:0] imm_t;
    typedef logic [25:0] jidx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // Link register for JAL.
    localparam reg_addr_t REG_RA = 5'd31;

    //////////////////////////////////////////////////
    // Opcodes.
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDI    = 6'h08;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    //////////////////////////////////////////////////
    // Function codes of SPECIAL.
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_JALR = 6'h09;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;

endpackage

//--- verilog/id_ctrl_pkg.sv
package id_ctrl_pkg;

    // ALUOp from the main control.
    typedef logic [1:0] alu_op_t;

    localparam alu_op_t ALUOP_ADD   = 2'b00;
    localparam alu_op_t ALUOP_SUB   = 2'b01;
    localparam alu_op_t ALUOP_FUNCT = 2'b10;
    localparam alu_op_t ALUOP_IMM   = 2'b11;

    // Operation code seen by the execute stage ALU.
    typedef logic [3:0] alu_ctrl_t;

    localparam alu_ctrl_t ALU_ADD = 4'h0;
    localparam alu_ctrl_t ALU_SUB = 4'h1;
    localparam alu_ctrl_t ALU_AND = 4'h2;
    localparam alu_ctrl_t ALU_OR  = 4'h3;
    localparam alu_ctrl_t ALU_XOR = 4'h4;
    localparam alu_ctrl_t ALU_NOR = 4'h5;
    localparam alu_ctrl_t ALU_SLT = 4'h6;
    localparam alu_ctrl_t ALU_SLL = 4'h7;
    localparam alu_ctrl_t ALU_SRL = 4'h8;
    localparam alu_ctrl_t ALU_SRA = 4'h9;
    localparam alu_ctrl_t ALU_LUI = 4'ha;

    // Kind of control transfer resolved in decode.
    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JAL, BR_JR, BR_JALR
    } branch_kind_t;

endpackage

//--- verilog/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  instr_t       i_instruction,
    output opcode_t      o_opcode,
    output funct_t       o_funct,
    output reg_addr_t    o_rs,
    output reg_addr_t    o_rt,
    output reg_addr_t    o_rd,
    output logic [4:0]   o_shamt,
    output word_t        o_imm_ext,
    output jidx_t        o_jidx,
    output branch_kind_t o_branch_kind
);

    imm_t imm_raw;

    assign o_opcode = i_instruction[31:26];
    assign o_rs     = i_instruction[25:21];
    assign o_rt     = i_instruction[20:16];
    assign o_rd     = i_instruction[15:11];
    assign o_shamt  = i_instruction[10:6];
    assign o_funct  = i_instruction[5:0];
    assign o_jidx   = i_instruction[25:0];
    assign imm_raw  = i_instruction[15:0];

    // Logical immediates are zero extended.
    always_comb begin
        if (o_opcode == OP_ANDI || o_opcode == OP_ORI || o_opcode == OP_XORI) begin
            o_imm_ext = {16'h0000, imm_raw};
        end else begin
            o_imm_ext = {{16{imm_raw[15]}}, imm_raw};
        end
    end

    always_comb begin
        case (o_opcode)
            OP_BEQ:     o_branch_kind = BR_BEQ;
            OP_BNE:     o_branch_kind = BR_BNE;
            OP_J:       o_branch_kind = BR_J;
            OP_JAL:     o_branch_kind = BR_JAL;
            OP_SPECIAL: begin
                if (o_funct == FN_JR) begin
                    o_branch_kind = BR_JR;
                end else if (o_funct == FN_JALR) begin
                    o_branch_kind = BR_JALR;
                end else begin
                    o_branch_kind = BR_NONE;
                end
            end
            default:    o_branch_kind = BR_NONE;
        endcase
    end

endmodule

//--- verilog/main_control.sv
`timescale 1ns/100ps

module main_control
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  opcode_t   i_opcode,
    input  funct_t    i_funct,
    output logic      o_reg_dst,
    output logic      o_reg_write,
    output logic      o_alu_src,
    output logic      o_mem_read,
    output logic      o_mem_write,
    output logic      o_mem_to_reg,
    output logic      o_link,
    output alu_op_t   o_alu_op,
    output alu_ctrl_t o_alu_ctrl
);

    //////////////////////////////////////////////////
    // Main decode table.
    always_comb begin
        o_reg_dst    = 1'b0;
        o_reg_write  = 1'b0;
        o_alu_src    = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_to_reg = 1'b0;
        o_link       = 1'b0;
        o_alu_op     = ALUOP_ADD;
        case (i_opcode)
            OP_SPECIAL: begin
                o_alu_op = ALUOP_FUNCT;
                if (i_funct != FN_JR) begin
                    o_reg_dst   = 1'b1;
                    o_reg_write = 1'b1;
                    o_link      = (i_funct == FN_JALR);
                end
            end
            OP_LW: begin
                o_alu_src    = 1'b1;
                o_mem_read   = 1'b1;
                o_mem_to_reg = 1'b1;
                o_reg_write  = 1'b1;
            end
            OP_SW: begin
                o_alu_src   = 1'b1;
                o_mem_write = 1'b1;
            end
            OP_ADDI: begin
                o_alu_src   = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                o_alu_src   = 1'b1;
                o_reg_write = 1'b1;
                o_alu_op    = ALUOP_IMM;
            end
            OP_JAL: begin
                o_reg_write = 1'b1;
                o_link      = 1'b1;
            end
            OP_BEQ, OP_BNE: o_alu_op = ALUOP_SUB;
            // J and unknown opcodes write nothing.
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // ALU control table.
    always_comb begin
        o_alu_ctrl = ALU_ADD;
        case (o_alu_op)
            ALUOP_SUB:   o_alu_ctrl = ALU_SUB;
            ALUOP_FUNCT: begin
                case (i_funct)
                    FN_SLL:  o_alu_ctrl = ALU_SLL;
                    FN_SRL:  o_alu_ctrl = ALU_SRL;
                    FN_SRA:  o_alu_ctrl = ALU_SRA;
                    FN_ADD:  o_alu_ctrl = ALU_ADD;
                    FN_SUB:  o_alu_ctrl = ALU_SUB;
                    FN_AND:  o_alu_ctrl = ALU_AND;
                    FN_OR:   o_alu_ctrl = ALU_OR;
                    FN_XOR:  o_alu_ctrl = ALU_XOR;
                    FN_NOR:  o_alu_ctrl = ALU_NOR;
                    FN_SLT:  o_alu_ctrl = ALU_SLT;
                    default: o_alu_ctrl = ALU_ADD; // JR and JALR pass through
                endcase
            end
            ALUOP_IMM: begin
                case (i_opcode)
                    OP_SLTI: o_alu_ctrl = ALU_SLT;
                    OP_ANDI: o_alu_ctrl = ALU_AND;
                    OP_ORI:  o_alu_ctrl = ALU_OR;
                    OP_XORI: o_alu_ctrl = ALU_XOR;
                    OP_LUI:  o_alu_ctrl = ALU_LUI;
                    default: o_alu_ctrl = ALU_ADD;
                endcase
            end
            default:     o_alu_ctrl = ALU_ADD;
        endcase
    end

    // A memory access is a load or a store, never both.
    a_mem_excl: assert final (!(o_mem_read && o_mem_write));

endmodule

//--- verilog/register_file.sv
`timescale 1ns/100ps

module register_file
    import mips_isa_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_rst_n,
    input  reg_addr_t i_rd_addr_a,
    input  reg_addr_t i_rd_addr_b,
    input  logic      i_wr_en,
    input  reg_addr_t i_wr_addr,
    input  word_t     i_wr_data,
    output word_t     o_rd_data_a,
    output word_t     o_rd_data_b
);

    word_t regs [NUM_REGS];

    // Register 0 is hardwired and a pending write wins over the array.
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (i_wr_en && (i_wr_addr == addr)) begin
            data = i_wr_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_rd_data_a = read_port(i_rd_addr_a);
    assign o_rd_data_b = read_port(i_rd_addr_b);

    //////////////////////////////////////////////////
    // Zero register holds even under a write to it.
    a_zero_reg: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        ((i_rd_addr_a == '0) |-> (o_rd_data_a == '0)) and
        ((i_rd_addr_b == '0) |-> (o_rd_data_b == '0)));

endmodule

//--- verilog/branch_address_calculator.sv
`timescale 1ns/100ps

module branch_address_calculator
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  branch_kind_t i_branch_kind,
    input  pc_addr_t     i_pc_plus1,
    input  word_t        i_data_a,
    input  word_t        i_data_b,
    input  word_t        i_imm_ext,
    input  jidx_t        i_jidx,
    output logic         o_branch_taken,
    output pc_addr_t     o_branch_target
);

    logic     operands_equal;
    pc_addr_t rel_target;

    assign operands_equal = (i_data_a == i_data_b);

    // Relative offset wraps within the word address space.
    assign rel_target = i_pc_plus1 + i_imm_ext[10:0];

    always_comb begin
        o_branch_taken  = 1'b0;
        o_branch_target = '0;
        case (i_branch_kind)
            BR_BEQ: begin
                o_branch_taken  = operands_equal;
                o_branch_target = operands_equal ? rel_target : '0;
            end
            BR_BNE: begin
                o_branch_taken  = !operands_equal;
                o_branch_target = operands_equal ? '0 : rel_target;
            end
            BR_J, BR_JAL: begin
                o_branch_taken  = 1'b1;
                o_branch_target = i_jidx[10:0];
            end
            BR_JR, BR_JALR: begin
                o_branch_taken  = 1'b1;
                o_branch_target = i_data_a[10:0];
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/id_ex_register.sv
`timescale 1ns/100ps

module id_ex_register
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_rst_n,
    input  word_t      i_data_a,
    input  word_t      i_data_b,
    input  word_t      i_imm_ext,
    input  logic [4:0] i_shamt,
    input  reg_addr_t  i_rs,
    input  reg_addr_t  i_rt,
    input  reg_addr_t  i_rd,
    input  logic       i_reg_dst,
    input  logic       i_reg_write,
    input  logic       i_alu_src,
    input  logic       i_mem_read,
    input  logic       i_mem_write,
    input  logic       i_mem_to_reg,
    input  logic       i_link,
    input  alu_op_t    i_alu_op,
    input  alu_ctrl_t  i_alu_ctrl,
    output word_t      o_ex_data_a,
    output word_t      o_ex_data_b,
    output word_t      o_ex_imm_ext,
    output logic [4:0] o_ex_shamt,
    output reg_addr_t  o_ex_rs,
    output reg_addr_t  o_ex_rt,
    output reg_addr_t  o_ex_wr_reg,
    output logic       o_ex_reg_write,
    output logic       o_ex_alu_src,
    output logic       o_ex_mem_read,
    output logic       o_ex_mem_write,
    output logic       o_ex_mem_to_reg,
    output logic       o_ex_link,
    output alu_op_t    o_ex_alu_op,
    output alu_ctrl_t  o_ex_alu_ctrl
);

    reg_addr_t wr_reg;

    // JALR keeps rd as its destination.
    assign wr_reg = i_reg_dst ? i_rd : (i_link ? REG_RA : i_rt);

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_ex_data_a     <= '0;
            o_ex_data_b     <= '0;
            o_ex_imm_ext    <= '0;
            o_ex_shamt      <= '0;
            o_ex_rs         <= '0;
            o_ex_rt         <= '0;
            o_ex_wr_reg     <= '0;
            o_ex_reg_write  <= 1'b0;
            o_ex_alu_src    <= 1'b0;
            o_ex_mem_read   <= 1'b0;
            o_ex_mem_write  <= 1'b0;
            o_ex_mem_to_reg <= 1'b0;
            o_ex_link       <= 1'b0;
            o_ex_alu_op     <= ALUOP_ADD;
            o_ex_alu_ctrl   <= ALU_ADD;
        end else begin
            o_ex_data_a     <= i_data_a;
            o_ex_data_b     <= i_data_b;
            o_ex_imm_ext    <= i_imm_ext;
            o_ex_shamt      <= i_shamt;
            o_ex_rs         <= i_rs;
            o_ex_rt         <= i_rt;
            o_ex_wr_reg     <= wr_reg;
            o_ex_reg_write  <= i_reg_write;
            o_ex_alu_src    <= i_alu_src;
            o_ex_mem_read   <= i_mem_read;
            o_ex_mem_write  <= i_mem_write;
            o_ex_mem_to_reg <= i_mem_to_reg;
            o_ex_link       <= i_link;
            o_ex_alu_op     <= i_alu_op;
            o_ex_alu_ctrl   <= i_alu_ctrl;
        end
    end

    // No write reaches execute right after reset.
    a_rst_quiet: assert property (@(posedge i_clock) !i_rst_n |=>
        !(o_ex_reg_write || o_ex_mem_read || o_ex_mem_write || o_ex_mem_to_reg));

endmodule

//--- verilog/top_id.sv
`timescale 1ns/100ps

module top_id
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_rst_n,
    input  instr_t     i_instruction,
    input  pc_addr_t   i_pc_plus1,
    input  logic       i_wb_en,
    input  reg_addr_t  i_wb_addr,
    input  word_t      i_wb_data,
    output logic       o_branch_taken,
    output pc_addr_t   o_branch_target,
    output word_t      o_ex_data_a,
    output word_t      o_ex_data_b,
    output word_t      o_ex_imm_ext,
    output logic [4:0] o_ex_shamt,
    output reg_addr_t  o_ex_rs,
    output reg_addr_t  o_ex_rt,
    output reg_addr_t  o_ex_wr_reg,
    output logic       o_ex_reg_write,
    output logic       o_ex_alu_src,
    output logic       o_ex_mem_read,
    output logic       o_ex_mem_write,
    output logic       o_ex_mem_to_reg,
    output logic       o_ex_link,
    output alu_op_t    o_ex_alu_op,
    output alu_ctrl_t  o_ex_alu_ctrl
);

    opcode_t      opcode;
    funct_t       funct;
    reg_addr_t    rs;
    reg_addr_t    rt;
    reg_addr_t    rd;
    logic [4:0]   shamt;
    word_t        imm_ext;
    jidx_t        jidx;
    branch_kind_t branch_kind;
    word_t        data_a;
    word_t        data_b;

    // Control bundle.
    logic      reg_dst;
    logic      reg_write;
    logic      alu_src;
    logic      mem_read;
    logic      mem_write;
    logic      mem_to_reg;
    logic      link;
    alu_op_t   alu_op;
    alu_ctrl_t alu_ctrl;

    //////////////////////////////////////////////////
    instr_decoder u_instr_decoder (
        .i_instruction (i_instruction),
        .o_opcode      (opcode),
        .o_funct       (funct),
        .o_rs          (rs),
        .o_rt          (rt),
        .o_rd          (rd),
        .o_shamt       (shamt),
        .o_imm_ext     (imm_ext),
        .o_jidx        (jidx),
        .o_branch_kind (branch_kind)
    );

    register_file u_register_file (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_rd_addr_a (rs),
        .i_rd_addr_b (rt),
        .i_wr_en     (i_wb_en),
        .i_wr_addr   (i_wb_addr),
        .i_wr_data   (i_wb_data),
        .o_rd_data_a (data_a),
        .o_rd_data_b (data_b)
    );

    branch_address_calculator u_branch_address_calculator (
        .i_branch_kind   (branch_kind),
        .i_pc_plus1      (i_pc_plus1),
        .i_data_a        (data_a),
        .i_data_b        (data_b),
        .i_imm_ext       (imm_ext),
        .i_jidx          (jidx),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target)
    );

    main_control u_main_control (
        .i_opcode     (opcode),
        .i_funct      (funct),
        .o_reg_dst    (reg_dst),
        .o_reg_write  (reg_write),
        .o_alu_src    (alu_src),
        .o_mem_read   (mem_read),
        .o_mem_write  (mem_write),
        .o_mem_to_reg (mem_to_reg),
        .o_link       (link),
        .o_alu_op     (alu_op),
        .o_alu_ctrl   (alu_ctrl)
    );

    //////////////////////////////////////////////////
    id_ex_register u_id_ex_register (
        .i_clock         (i_clock),
        .i_rst_n         (i_rst_n),
        .i_data_a        (data_a),
        .i_data_b        (data_b),
        .i_imm_ext       (imm_ext),
        .i_shamt         (shamt),
        .i_rs            (rs),
        .i_rt            (rt),
        .i_rd            (rd),
        .i_reg_dst       (reg_dst),
        .i_reg_write     (reg_write),
        .i_alu_src       (alu_src),
        .i_mem_read      (mem_read),
        .i_mem_write     (mem_write),
        .i_mem_to_reg    (mem_to_reg),
        .i_link          (link),
        .i_alu_op        (alu_op),
        .i_alu_ctrl      (alu_ctrl),
        .o_ex_data_a     (o_ex_data_a),
        .o_ex_data_b     (o_ex_data_b),
        .o_ex_imm_ext    (o_ex_imm_ext),
        .o_ex_shamt      (o_ex_shamt),
        .o_ex_rs         (o_ex_rs),
        .o_ex_rt         (o_ex_rt),
        .o_ex_wr_reg     (o_ex_wr_reg),
        .o_ex_reg_write  (o_ex_reg_write),
        .o_ex_alu_src    (o_ex_alu_src),
        .o_ex_mem_read   (o_ex_mem_read),
        .o_ex_mem_write  (o_ex_mem_write),
        .o_ex_mem_to_reg (o_ex_mem_to_reg),
        .o_ex_link       (o_ex_link),
        .o_ex_alu_op     (o_ex_alu_op),
        .o_ex_alu_ctrl   (o_ex_alu_ctrl)
    );

endmodule

//--- verification/tb_top_id.sv
`timescale 1ns/100ps

module tb_top_id
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
();

    logic       i_clock;
    logic       i_rst_n;
    instr_t     i_instruction;
    pc_addr_t   i_pc_plus1;
    logic       i_wb_en;
    reg_addr_t  i_wb_addr;
    word_t      i_wb_data;
    logic       o_branch_taken;
    pc_addr_t   o_branch_target;
    word_t      o_ex_data_a, o_ex_data_b, o_ex_imm_ext;
    logic [4:0] o_ex_shamt;
    reg_addr_t  o_ex_rs, o_ex_rt, o_ex_wr_reg;
    logic       o_ex_reg_write, o_ex_alu_src, o_ex_mem_read, o_ex_mem_write;
    logic       o_ex_mem_to_reg, o_ex_link;
    alu_op_t    o_ex_alu_op;
    alu_ctrl_t  o_ex_alu_ctrl;

    // Shadow register file and expected stage outputs.
    word_t       shadow [NUM_REGS];
    logic [31:0] lcg_state = 32'd54;
    logic        check_en;
    word_t       exp_data_a, exp_data_b, exp_imm;
    logic [4:0]  exp_shamt;
    reg_addr_t   exp_rs, exp_rt, exp_wr_reg;
    logic [11:0] exp_ctrl;
    logic        exp_taken;
    pc_addr_t    exp_target;

    funct_t  r_functs [10] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR,
                               FN_NOR, FN_SLT, FN_SLL, FN_SRL, FN_SRA};
    opcode_t imm_ops [6]   = '{OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

    top_id i_dut (.*);

    always #10 i_clock = ~i_clock;

    //////////////////////////////////////////////////
    task automatic stop_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        $display("Mismatch on %s: got 0x%h, expected 0x%h", name, got, want);
        stop_run();
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic instr_t r_type(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                      logic [4:0] sh, funct_t fn);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic instr_t i_type(opcode_t op, reg_addr_t rs, reg_addr_t rt, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    // Register read as seen in decode with the write-back bypass.
    function automatic word_t expected_read(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (i_wb_en && i_wb_addr == addr) begin
            return i_wb_data;
        end
        return shadow[addr];
    endfunction

    function automatic word_t expected_imm(instr_t ins);
        opcode_t op;
        op = ins[31:26];
        if (op == OP_ANDI || op == OP_ORI || op == OP_XORI) begin
            return {16'h0000, ins[15:0]};
        end
        return {{16{ins[15]}}, ins[15:0]};
    endfunction

    // JR sets no RegDst and falls back to rt.
    function automatic reg_addr_t expected_dest(instr_t ins);
        if (ins[31:26] == OP_SPECIAL && ins[5:0] != FN_JR) begin
            return ins[15:11];
        end else if (ins[31:26] == OP_JAL) begin
            return REG_RA;
        end
        return ins[20:16];
    endfunction

    // Flags are reg_write, alu_src, mem_read, mem_write, mem_to_reg, link.
    function automatic logic [11:0] expected_controls(instr_t ins);
        logic [5:0] flags;
        alu_op_t    aop;
        alu_ctrl_t  actl;
        flags = 6'b000000;
        aop   = ALUOP_ADD;
        actl  = ALU_ADD;
        case (ins[31:26])
            OP_SPECIAL: begin
                aop = ALUOP_FUNCT;
                case (ins[5:0])
                    FN_SUB:  actl = ALU_SUB;
                    FN_AND:  actl = ALU_AND;
                    FN_OR:   actl = ALU_OR;
                    FN_XOR:  actl = ALU_XOR;
                    FN_NOR:  actl = ALU_NOR;
                    FN_SLT:  actl = ALU_SLT;
                    FN_SLL:  actl = ALU_SLL;
                    FN_SRL:  actl = ALU_SRL;
                    FN_SRA:  actl = ALU_SRA;
                    default: actl = ALU_ADD;
                endcase
                if (ins[5:0] == FN_JALR) begin
                    flags = 6'b100001;
                end else if (ins[5:0] != FN_JR) begin
                    flags = 6'b100000;
                end
            end
            OP_LW:   flags = 6'b111010;
            OP_SW:   flags = 6'b010100;
            OP_ADDI: flags = 6'b110000;
            OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                flags = 6'b110000;
                aop   = ALUOP_IMM;
                case (ins[31:26])
                    OP_SLTI: actl = ALU_SLT;
                    OP_ANDI: actl = ALU_AND;
                    OP_ORI:  actl = ALU_OR;
                    OP_XORI: actl = ALU_XOR;
                    default: actl = ALU_LUI;
                endcase
            end
            OP_JAL:  flags = 6'b100001;
            OP_BEQ, OP_BNE: begin
                aop  = ALUOP_SUB;
                actl = ALU_SUB;
            end
            default: ;
        endcase
        return {flags, aop, actl};
    endfunction

    // Drives the inputs and sets the branch result expected in this cycle.
    task automatic drive(instr_t ins, pc_addr_t pc, logic we, reg_addr_t wa, word_t wd);
        word_t ra;
        word_t rb;
        i_instruction = ins;
        i_pc_plus1    = pc;
        i_wb_en       = we;
        i_wb_addr     = wa;
        i_wb_data     = wd;
        ra            = expected_read(ins[25:21]);
        rb            = expected_read(ins[20:16]);
        exp_taken     = 1'b0;
        exp_target    = '0;
        if ((ins[31:26] == OP_BEQ && ra == rb) || (ins[31:26] == OP_BNE && ra != rb)) begin
            exp_taken  = 1'b1;
            exp_target = pc + ins[10:0];
        end else if (ins[31:26] == OP_J || ins[31:26] == OP_JAL) begin
            exp_taken  = 1'b1;
            exp_target = ins[10:0];
        end else if (ins[31:26] == OP_SPECIAL && (ins[5:0] == FN_JR || ins[5:0] == FN_JALR)) begin
            exp_taken  = 1'b1;
            exp_target = ra[10:0];
        end
    endtask

    task automatic issue(instr_t ins, pc_addr_t pc, logic we, reg_addr_t wa, word_t wd);
        @(posedge i_clock);
        #2;
        drive(ins, pc, we, wa, wd);
    endtask

    task automatic wait_reset_clear();
        int cycles;
        cycles = 0;
        while (o_ex_reg_write || o_ex_mem_read || o_ex_mem_write || o_ex_mem_to_reg) begin
            if (cycles == 8) begin
                $display("Timeout: ID/EX write controls stayed high after reset");
                stop_run();
            end else begin
                @(negedge i_clock);
                cycles++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model taking one instruction per edge.
    always @(posedge i_clock) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                shadow[i] <= '0;
            end
            exp_data_a <= '0;
            exp_data_b <= '0;
            exp_imm    <= '0;
            exp_shamt  <= '0;
            exp_rs     <= '0;
            exp_rt     <= '0;
            exp_wr_reg <= '0;
            exp_ctrl   <= '0;
        end else begin
            exp_data_a <= expected_read(i_instruction[25:21]);
            exp_data_b <= expected_read(i_instruction[20:16]);
            exp_imm    <= expected_imm(i_instruction);
            exp_shamt  <= i_instruction[10:6];
            exp_rs     <= i_instruction[25:21];
            exp_rt     <= i_instruction[20:16];
            exp_wr_reg <= expected_dest(i_instruction);
            exp_ctrl   <= expected_controls(i_instruction);
            if (i_wb_en && i_wb_addr != '0) begin
                shadow[i_wb_addr] <= i_wb_data;
            end
        end
    end

    property equals_expected(got, want);
        @(posedge i_clock) disable iff (!check_en) got == want;
    endproperty

    a_taken: assert property (equals_expected(o_branch_taken, exp_taken))
        else show_mismatch("o_branch_taken", $sampled(o_branch_taken), $sampled(exp_taken));
    a_target: assert property (equals_expected(o_branch_target, exp_target))
        else show_mismatch("o_branch_target", $sampled(o_branch_target), $sampled(exp_target));
    a_data_a: assert property (equals_expected(o_ex_data_a, exp_data_a))
        else show_mismatch("o_ex_data_a", $sampled(o_ex_data_a), $sampled(exp_data_a));
    a_data_b: assert property (equals_expected(o_ex_data_b, exp_data_b))
        else show_mismatch("o_ex_data_b", $sampled(o_ex_data_b), $sampled(exp_data_b));
    a_imm: assert property (equals_expected(o_ex_imm_ext, exp_imm))
        else show_mismatch("o_ex_imm_ext", $sampled(o_ex_imm_ext), $sampled(exp_imm));
    a_shamt: assert property (equals_expected(o_ex_shamt, exp_shamt))
        else show_mismatch("o_ex_shamt", $sampled(o_ex_shamt), $sampled(exp_shamt));
    a_rs: assert property (equals_expected(o_ex_rs, exp_rs))
        else show_mismatch("o_ex_rs", $sampled(o_ex_rs), $sampled(exp_rs));
    a_rt: assert property (equals_expected(o_ex_rt, exp_rt))
        else show_mismatch("o_ex_rt", $sampled(o_ex_rt), $sampled(exp_rt));
    a_wr_reg: assert property (equals_expected(o_ex_wr_reg, exp_wr_reg))
        else show_mismatch("o_ex_wr_reg", $sampled(o_ex_wr_reg), $sampled(exp_wr_reg));
    a_reg_write: assert property (equals_expected(o_ex_reg_write, exp_ctrl[11]))
        else show_mismatch("o_ex_reg_write", $sampled(o_ex_reg_write), $sampled(exp_ctrl[11]));
    a_alu_src: assert property (equals_expected(o_ex_alu_src, exp_ctrl[10]))
        else show_mismatch("o_ex_alu_src", $sampled(o_ex_alu_src), $sampled(exp_ctrl[10]));
    a_mem_read: assert property (equals_expected(o_ex_mem_read, exp_ctrl[9]))
        else show_mismatch("o_ex_mem_read", $sampled(o_ex_mem_read), $sampled(exp_ctrl[9]));
    a_mem_write: assert property (equals_expected(o_ex_mem_write, exp_ctrl[8]))
        else show_mismatch("o_ex_mem_write", $sampled(o_ex_mem_write), $sampled(exp_ctrl[8]));
    a_mem_to_reg: assert property (equals_expected(o_ex_mem_to_reg, exp_ctrl[7]))
        else show_mismatch("o_ex_mem_to_reg", $sampled(o_ex_mem_to_reg), $sampled(exp_ctrl[7]));
    a_link: assert property (equals_expected(o_ex_link, exp_ctrl[6]))
        else show_mismatch("o_ex_link", $sampled(o_ex_link), $sampled(exp_ctrl[6]));
    a_alu_op: assert property (equals_expected(o_ex_alu_op, exp_ctrl[5:4]))
        else show_mismatch("o_ex_alu_op", $sampled(o_ex_alu_op), $sampled(exp_ctrl[5:4]));
    a_alu_ctrl: assert property (equals_expected(o_ex_alu_ctrl, exp_ctrl[3:0]))
        else show_mismatch("o_ex_alu_ctrl", $sampled(o_ex_alu_ctrl), $sampled(exp_ctrl[3:0]));

    a_mem_excl: assert property (@(posedge i_clock) disable iff (!check_en)
        !(o_ex_mem_read && o_ex_mem_write))
        else begin
            $display("Load and store controls were both high in ID/EX");
            stop_run();
        end
    a_rst_clear: assert property (@(posedge i_clock) !i_rst_n |=>
        !(o_ex_reg_write || o_ex_mem_read || o_ex_mem_write || o_ex_mem_to_reg))
        else begin
            $display("ID/EX write controls were not cleared by reset");
            stop_run();
        end

    //////////////////////////////////////////////////
    initial begin
        #100000;
        $display("Timeout: simulation did not reach its end");
        stop_run();
    end

    initial begin
        logic [31:0] rnd;
        word_t       v;
        i_clock  = 1'b0;
        i_rst_n  = 1'b0;
        check_en = 1'b0;
        drive('0, '0, 1'b0, '0, '0);
        repeat (3) @(posedge i_clock);
        #2;
        i_rst_n  = 1'b1;
        check_en = 1'b1;
        wait_reset_clear();

        // Every register reads zero after reset.
        for (int r = 0; r < NUM_REGS; r++) begin
            issue(r_type(reg_addr_t'(r), reg_addr_t'(31 - r), 5'd1, 5'd0, FN_ADD),
                  11'd1, 1'b0, '0, '0);
        end

        // About half the reads hit the register being written back.
        for (int n = 0; n < 48; n++) begin
            rnd = next_random();
            v   = next_random();
            issue(r_type(rnd[31] ? rnd[4:0] : rnd[9:5], rnd[14:10], rnd[19:15], rnd[24:20],
                  FN_OR), rnd[10:0], rnd[30] | rnd[29], rnd[4:0], v);
        end
        issue(r_type(5'd0, 5'd0, 5'd2, 5'd0, FN_ADD), 11'd0, 1'b1, 5'd0, 32'hffff_ffff);
        issue(r_type(5'd0, 5'd0, 5'd2, 5'd0, FN_ADD), 11'd0, 1'b0, 5'd0, '0);

        foreach (r_functs[k]) begin
            rnd = next_random();
            issue(r_type(rnd[4:0], rnd[9:5], rnd[14:10], rnd[19:15], r_functs[k]),
                  rnd[30:20], 1'b0, '0, '0);
        end
        foreach (imm_ops[k]) begin
            for (int s = 0; s < 2; s++) begin
                rnd = next_random();
                issue(i_type(imm_ops[k], rnd[4:0], rnd[9:5], {s[0], rnd[24:10]}),
                      rnd[31:21], 1'b0, '0, '0);
            end
        end

        // Loads and stores with both offset signs.
        for (int n = 0; n < 16; n++) begin
            rnd = next_random();
            issue(i_type(n[0] ? OP_SW : OP_LW, rnd[4:0], rnd[9:5], {n[1], rnd[24:10]}),
                  rnd[31:21], 1'b0, '0, '0);
        end

        // Branch operands arrive through write-through.
        for (int n = 0; n < 8; n++) begin
            v   = next_random();
            rnd = next_random();
            issue(i_type(OP_BEQ, 5'd5, 5'd5, rnd[15:0]), rnd[26:16], 1'b1, 5'd5, v);
            issue(i_type(OP_BEQ, 5'd5, 5'd6, rnd[15:0]), rnd[26:16], 1'b1, 5'd6, ~v);
            issue(i_type(OP_BNE, 5'd5, 5'd6, rnd[15:0]), rnd[26:16], 1'b0, '0, '0);
            issue(i_type(OP_BNE, 5'd6, 5'd6, rnd[15:0]), rnd[26:16], 1'b0, '0, '0);
        end

        for (int n = 0; n < 8; n++) begin
            rnd = next_random();
            issue({OP_J, rnd[25:0]}, rnd[31:21], 1'b0, '0, '0);
            issue({OP_JAL, rnd[25:0]}, rnd[31:21], 1'b0, '0, '0);
            issue(r_type(rnd[4:0], rnd[19:15], rnd[14:10], 5'd0, FN_JR),
                  rnd[31:21], 1'b0, '0, '0);
            issue(r_type(rnd[9:5], 5'd0, rnd[14:10], 5'd0, FN_JALR), rnd[31:21], 1'b0, '0, '0);
        end

        issue(r_type(5'd1, 5'd2, 5'd3, 5'd0, FN_ADD), 11'd0, 1'b0, '0, '0);
        @(negedge i_clock);
        @(negedge i_clock);
        $display("No errors");
        $finish;
    end

endmodule

//--- src.f
verilog/mips_isa_pkg.sv
verilog/id_ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/main_control.sv
verilog/register_file.sv
verilog/branch_address_calculator.sv
verilog/id_ex_register.sv
verilog/top_id.sv
verification/tb_top_id.sv

//--- Bender.yml
package:
  name: mips_id_stage

sources:
  - verilog/mips_isa_pkg.sv
  - verilog/id_ctrl_pkg.sv
  - verilog/instr_decoder.sv
  - verilog/main_control.sv
  - verilog/register_file.sv
  - verilog/branch_address_calculator.sv
  - verilog/id_ex_register.sv
  - verilog/top_id.sv
  - target: test
    files:
      - verification/tb_top_id.sv
